/* compile.f */
hw/rv_isa_pkg.sv
hw/dispatch_pkg.sv
hw/control.sv
hw/alu_mux.sv
hw/instruction_decompose.sv
hw/register_status.sv
hw/decode_stage.sv
sim/decode_stage_assertions.sv
sim/decode_stage_tb.sv

/* hw/alu_mux.sv */
`timescale 1ns/1ns

module alu_mux (
    input  dispatch_pkg::op1_sel_e op1_sel,
    input  dispatch_pkg::op2_sel_e op2_sel,
    input  logic                   store_imm,
    input  rv_isa_pkg::rv_inst_u   inst,
    input  logic [31:0]            rs1_vt,
    input  logic [31:0]            rs2_vt,
    input  logic [31:0]            pc,
    output logic [31:0]            op1,
    output logic [31:0]            op2
);
    import dispatch_pkg::*;

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    logic [31:0] shamt;

    assign imm_i = {{20{inst.i.imm12[11]}}, inst.i.imm12};
    assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_u = {inst.u.imm20, 12'b0};
    assign shamt = {27'b0, inst.r.rs2};      // Shift amount sits in the rs2 slot

    always_comb begin
        case (op1_sel)
            OP1_REG: op1 = rs1_vt;
            OP1_PC:  op1 = pc;
            default: op1 = '0;
        endcase
    end

    always_comb begin
        case (op2_sel)
            OP2_REG:   op2 = rs2_vt;
            OP2_IMM_I: op2 = store_imm ? imm_s : imm_i;
            OP2_IMM_U: op2 = imm_u;
            default:   op2 = shamt;
        endcase
    end

endmodule

/* hw/control.sv */
`timescale 1ns/1ns

module control (
    input  logic [6:0]             opcode,
    input  logic [2:0]             funct3,
    input  logic [6:0]             funct7,
    input  rv_isa_pkg::reg_idx_t   rd,
    output dispatch_pkg::ctrl_t    ctrl,
    output dispatch_pkg::op1_sel_e op1_sel,
    output dispatch_pkg::op2_sel_e op2_sel,
    output logic                   store_imm,
    output logic                   map_en
);
    import rv_isa_pkg::*;
    import dispatch_pkg::*;

    // funct3 decode shared by the register and immediate ALU forms
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl      = '0;              // Unknown opcode stays all zero
        op1_sel   = OP1_REG;
        op2_sel   = OP2_REG;
        store_imm = 1'b0;
        case (opcode)
            OP_REG: begin
                ctrl.aluop    = arith_op(funct3, funct7[5]);
                ctrl.regwrite = 1'b1;
            end
            OP_IMM: begin
                // Only SRAI uses funct7, ADDI has no subtract form
                ctrl.aluop    = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
                ctrl.regwrite = 1'b1;
                op2_sel       = (funct3[1:0] == 2'b01) ? OP2_SHAMT : OP2_IMM_I;
            end
            OP_LUI: begin
                ctrl.regwrite = 1'b1;
                op1_sel       = OP1_ZERO;
                op2_sel       = OP2_IMM_U;
            end
            OP_AUIPC: begin
                ctrl.regwrite = 1'b1;
                op1_sel       = OP1_PC;
                op2_sel       = OP2_IMM_U;
            end
            OP_LOAD: begin
                ctrl.memread  = 1'b1;
                ctrl.memtoreg = 1'b1;
                ctrl.regwrite = 1'b1;
                ctrl.rs_class = RS_LSU;
                op2_sel       = OP2_IMM_I;   // Address base plus offset
            end
            OP_STORE: begin
                ctrl.memwrite = 1'b1;
                ctrl.rs_class = RS_LSU;
                op2_sel       = OP2_IMM_I;
                store_imm     = 1'b1;        // Split S immediate
            end
            OP_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.rs_class = RS_BRANCH;
                case (funct3[2:1])
                    2'b10:   ctrl.aluop = ALU_SLT;   // BLT, BGE
                    2'b11:   ctrl.aluop = ALU_SLTU;  // BLTU, BGEU
                    default: ctrl.aluop = ALU_SUB;   // BEQ, BNE
                endcase
            end
            default: ;
        endcase
    end

    assign map_en = ctrl.regwrite && (rd != '0);  // x0 never renamed

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage #(
    parameter int TAG_WIDTH = 6
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_isa_pkg::rv_inst_u inst,
    input  logic [31:0]          pc,
    input  logic                 dispatch_en,  // Entry accepted downstream
    input  logic [TAG_WIDTH-1:0] alloc_tag,
    input  dispatch_pkg::wb_t    wb,
    input  logic [31:0]          ex_value,
    input  logic [31:0]          mem_value,
    input  dispatch_pkg::fwd_t   fwd,
    output dispatch_pkg::entry_t entry,
    output logic                 map_en,
    output rv_isa_pkg::reg_idx_t rs1,
    output rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::reg_idx_t rd
);

    logic [31:0] rs1_vt;
    logic        rs1_valid;
    logic [31:0] rs2_vt;
    logic        rs2_valid;

    register_status #(
        .TAG_WIDTH (TAG_WIDTH)
    ) u_register_status (
        .clk         (clk),
        .reset       (reset),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .map_en      (map_en),
        .dispatch_en (dispatch_en),
        .alloc_tag   (alloc_tag),
        .wb          (wb),
        .rs1_vt      (rs1_vt),
        .rs1_valid   (rs1_valid),
        .rs2_vt      (rs2_vt),
        .rs2_valid   (rs2_valid)
    );

    instruction_decompose u_instruction_decompose (
        .inst      (inst),
        .pc        (pc),
        .rs1_vt    (rs1_vt),
        .rs1_valid (rs1_valid),
        .rs2_vt    (rs2_vt),
        .rs2_valid (rs2_valid),
        .fwd       (fwd),
        .ex_value  (ex_value),
        .mem_value (mem_value),
        .map_en    (map_en),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .entry     (entry)
    );

endmodule

/* hw/dispatch_pkg.sv */
package dispatch_pkg;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9
    } alu_op_e;

    typedef enum logic [1:0] {OP1_REG, OP1_PC, OP1_ZERO} op1_sel_e;

    // S immediate rides on the IMM_I code, picked out by the store flag
    typedef enum logic [1:0] {OP2_REG, OP2_IMM_I, OP2_IMM_U, OP2_SHAMT} op2_sel_e;

    typedef enum logic [1:0] {RS_ALU, RS_LSU, RS_BRANCH} rs_class_e;

    typedef struct packed {
        alu_op_e   aluop;
        logic      memwrite;
        logic      memread;
        logic      memtoreg;
        logic      branch;
        logic      regwrite;
        rs_class_e rs_class;         // Target reservation station
    } ctrl_t;

    ////////////////////////////////////////////////////////////
    // Forwarding, writeback and RS entry
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        FWD_STATUS = 2'b00,          // 2'b11 also reads the status table
        FWD_EX     = 2'b01,
        FWD_MEM    = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        fwd_sel_e rs1_sel;
        fwd_sel_e rs2_sel;
    } fwd_t;

    typedef struct packed {
        logic        en;
        logic [7:0]  tag;            // Low TAG_WIDTH bits are significant
        logic [31:0] value;
    } wb_t;

    typedef struct packed {
        logic [31:0]          op2;
        logic                 valid2;
        logic [31:0]          op1;
        logic                 valid1;
        rv_isa_pkg::reg_idx_t rd;
        ctrl_t                ctrl;
    } entry_t;

endpackage

/* hw/instruction_decompose.sv */
`timescale 1ns/1ns

module instruction_decompose (
    input  rv_isa_pkg::rv_inst_u inst,
    input  logic [31:0]          pc,
    input  logic [31:0]          rs1_vt,
    input  logic                 rs1_valid,
    input  logic [31:0]          rs2_vt,
    input  logic                 rs2_valid,
    input  dispatch_pkg::fwd_t   fwd,
    input  logic [31:0]          ex_value,
    input  logic [31:0]          mem_value,
    output logic                 map_en,
    output rv_isa_pkg::reg_idx_t rs1,
    output rv_isa_pkg::reg_idx_t rs2,
    output rv_isa_pkg::reg_idx_t rd,
    output dispatch_pkg::entry_t entry
);
    import dispatch_pkg::*;

    ctrl_t       ctrl;
    op1_sel_e    op1_sel;
    op2_sel_e    op2_sel;
    logic        store_imm;
    logic [31:0] src1;               // Register operands after forwarding
    logic [31:0] src2;
    logic        src1_fwd;
    logic        src2_fwd;
    logic [31:0] op1;
    logic [31:0] op2;

    function automatic logic [31:0] fwd_value(input fwd_sel_e sel, input logic [31:0] vt,
                                              input logic [31:0] ex, input logic [31:0] mem);
        case (sel)
            FWD_EX:  return ex;
            FWD_MEM: return mem;
            default: return vt;      // Status table, code 11 included
        endcase
    endfunction

    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;
    assign rd  = inst.r.rd;

    control u_control (
        .opcode    (inst.r.opcode),
        .funct3    (inst.r.funct3),
        .funct7    (inst.r.funct7),
        .rd        (inst.r.rd),
        .ctrl      (ctrl),
        .op1_sel   (op1_sel),
        .op2_sel   (op2_sel),
        .store_imm (store_imm),
        .map_en    (map_en)
    );

    ////////////////////////////////////////////////////////////
    // Forwarding ahead of the operand mux
    ////////////////////////////////////////////////////////////

    assign src1     = fwd_value(fwd.rs1_sel, rs1_vt, ex_value, mem_value);
    assign src2     = fwd_value(fwd.rs2_sel, rs2_vt, ex_value, mem_value);
    assign src1_fwd = (fwd.rs1_sel == FWD_EX) || (fwd.rs1_sel == FWD_MEM);
    assign src2_fwd = (fwd.rs2_sel == FWD_EX) || (fwd.rs2_sel == FWD_MEM);

    alu_mux u_alu_mux (
        .op1_sel   (op1_sel),
        .op2_sel   (op2_sel),
        .store_imm (store_imm),
        .inst      (inst),
        .rs1_vt    (src1),
        .rs2_vt    (src2),
        .pc        (pc),
        .op1       (op1),
        .op2       (op2)
    );

    always_comb begin
        entry.op2    = op2;
        entry.valid2 = (op2_sel != OP2_REG) || src2_fwd || rs2_valid;
        entry.op1    = op1;
        entry.valid1 = (op1_sel != OP1_REG) || src1_fwd || rs1_valid;
        entry.rd     = rd;
        entry.ctrl   = ctrl;
    end

endmodule

/* hw/register_status.sv */
`timescale 1ns/1ns

module register_status #(
    parameter int TAG_WIDTH = 6
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    input  rv_isa_pkg::reg_idx_t rd,
    input  logic                 map_en,
    input  logic                 dispatch_en,
    input  logic [TAG_WIDTH-1:0] alloc_tag,
    input  dispatch_pkg::wb_t    wb,
    output logic [31:0]          rs1_vt,
    output logic                 rs1_valid,
    output logic [31:0]          rs2_vt,
    output logic                 rs2_valid
);
    import rv_isa_pkg::*;

    logic [31:0] vt_q [32];          // Value when valid, else rename tag
    logic [31:0] valid_q;
    logic        do_map;
    logic [31:0] wake;               // Per register writeback hit

    assign do_map = map_en && dispatch_en;

    always_comb begin
        for (int i = 0; i < 32; i++) begin
            wake[i] = wb.en && !valid_q[i]
                      && (vt_q[i][TAG_WIDTH-1:0] == wb.tag[TAG_WIDTH-1:0]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Map and wakeup, map has priority
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '1;
            for (int i = 0; i < 32; i++) begin
                vt_q[i] <= '0;
            end
        end else begin
            for (int i = 1; i < 32; i++) begin  // x0 left untouched
                if (do_map && (rd == reg_idx_t'(i))) begin
                    vt_q[i]    <= 32'(alloc_tag);
                    valid_q[i] <= 1'b0;
                end else if (wake[i]) begin
                    vt_q[i]    <= wb.value;
                    valid_q[i] <= 1'b1;
                end
            end
        end
    end

    // Old state only, bypass is done by forwarding
    assign rs1_vt    = vt_q[rs1];
    assign rs1_valid = valid_q[rs1];
    assign rs2_vt    = vt_q[rs2];
    assign rs2_valid = valid_q[rs2];

endmodule

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [4:0] reg_idx_t;   // Architectural register index

    ////////////////////////////////////////////////////////////
    // Instruction format views
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;          // imm[11:5]
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;          // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One word, read through whichever format the opcode calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } rv_inst_u;

    // Supported major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module decode_stage_tb \
    -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/decode_stage_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* sim/decode_stage_assertions.sv */
`timescale 1ns/1ns

module decode_stage_assertions (
    input logic                 clk,
    input logic                 reset,
    input rv_isa_pkg::rv_inst_u inst,
    input dispatch_pkg::fwd_t   fwd,
    input dispatch_pkg::entry_t entry,
    input logic                 map_en,
    input rv_isa_pkg::reg_idx_t rd
);
    import rv_isa_pkg::*;
    import dispatch_pkg::*;

    logic known_op;

    assign known_op = inst.r.opcode inside {OP_REG, OP_IMM, OP_LUI, OP_AUIPC,
                                            OP_LOAD, OP_STORE, OP_BRANCH};

    // x0 is never renamed
    no_x0_map: assert property (@(posedge clk) disable iff (reset)
        map_en |-> (rd != '0))
        else $error("map_en high with rd equal to x0");

    fwd_valid1: assert property (@(posedge clk) disable iff (reset)
        (fwd.rs1_sel inside {FWD_EX, FWD_MEM}) |-> entry.valid1)
        else $error("valid1 low with rs1 forwarded");

    fwd_valid2: assert property (@(posedge clk) disable iff (reset)
        (fwd.rs2_sel inside {FWD_EX, FWD_MEM}) |-> entry.valid2)
        else $error("valid2 low with rs2 forwarded");

    unknown_zero_ctrl: assert property (@(posedge clk) disable iff (reset)
        !known_op |-> (entry.ctrl == '0))
        else $error("nonzero control word for an unknown opcode");

endmodule

bind decode_stage decode_stage_assertions u_assertions (
    .clk    (clk),
    .reset  (reset),
    .inst   (inst),
    .fwd    (fwd),
    .entry  (entry),
    .map_en (map_en),
    .rd     (rd)
);

/* sim/decode_stage_tb.sv */
`timescale 1ns/1ns

module decode_stage_tb;
    import rv_isa_pkg::*;
    import dispatch_pkg::*;

    localparam int TAG_WIDTH = 6;
    localparam int SETTLE_NS = 20;         // Well inside the low clock phase

    typedef logic [TAG_WIDTH-1:0] tag_t;

    localparam fwd_t NO_FWD = fwd_t'{FWD_STATUS, FWD_STATUS};

    logic        clk;
    logic        reset;
    rv_inst_u    inst;
    logic [31:0] pc;
    logic        dispatch_en;
    tag_t        alloc_tag;
    wb_t         wb;
    logic [31:0] ex_value;
    logic [31:0] mem_value;
    fwd_t        fwd;
    entry_t      entry;
    logic        map_en;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;

    int fall_count;
    int test_errors;
    int total_errors;
    int tests_passed;
    int tests_failed;

    tag_t        x7_tag;                   // Left behind by the writeback test
    logic [31:0] x6_value;

    decode_stage #(
        .TAG_WIDTH (TAG_WIDTH)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .inst        (inst),
        .pc          (pc),
        .dispatch_en (dispatch_en),
        .alloc_tag   (alloc_tag),
        .wb          (wb),
        .ex_value    (ex_value),
        .mem_value   (mem_value),
        .fwd         (fwd),
        .entry       (entry),
        .map_en      (map_en),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd)
    );

    initial begin
        clk        = 1'b0;
        fall_count = 0;
        forever begin
            #50 clk = 1'b1;
            #50 clk = 1'b0;
            fall_count++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Timing, encoding and expected values
    ////////////////////////////////////////////////////////////

    task automatic wait_falls(input int n);
        int target;
        int ticks;
        target = fall_count + n;
        ticks  = 0;
        while ((fall_count < target) && (ticks < n * 100 + 50)) begin
            #1;
            ticks++;
        end
        if (fall_count < target) begin
            $display("Timeout: clock did not reach %0d falling edges", n);
            $display("Test FAILED");
            $finish;
        end
    endtask

    function automatic rv_inst_u enc_r(input logic [6:0] f7, input reg_idx_t s2,
                                       input reg_idx_t s1, input logic [2:0] f3,
                                       input reg_idx_t d, input logic [6:0] op);
        return {f7, s2, s1, f3, d, op};
    endfunction

    function automatic rv_inst_u enc_i(input logic [11:0] imm, input reg_idx_t s1,
                                       input logic [2:0] f3, input reg_idx_t d,
                                       input logic [6:0] op);
        return {imm, s1, f3, d, op};
    endfunction

    // Branches share this layout for the register fields
    function automatic rv_inst_u enc_s(input logic [11:0] imm, input reg_idx_t s2,
                                       input reg_idx_t s1, input logic [2:0] f3,
                                       input logic [6:0] op);
        return {imm[11:5], s2, s1, f3, imm[4:0], op};
    endfunction

    function automatic rv_inst_u enc_u(input logic [19:0] imm, input reg_idx_t d,
                                       input logic [6:0] op);
        return {imm, d, op};
    endfunction

    function automatic ctrl_t make_ctrl(input alu_op_e op, input logic mw, input logic mr,
                                        input logic m2r, input logic br, input logic rw,
                                        input rs_class_e cls);
        return '{op, mw, mr, m2r, br, rw, cls};
    endfunction

    function automatic ctrl_t alu_ctrl(input alu_op_e op);
        return make_ctrl(op, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, RS_ALU);
    endfunction

    function automatic entry_t make_entry(input logic [31:0] op2, input logic v2,
                                          input logic [31:0] op1, input logic v1,
                                          input reg_idx_t d, input ctrl_t c);
        return '{op2, v2, op1, v1, d, c};
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks and bookkeeping
    ////////////////////////////////////////////////////////////

    task automatic check_entry(input string label, input entry_t got, input entry_t exp);
        if (got !== exp) begin
            $display("** Error [%s] entry: got 0x%h, expected 0x%h", label, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_ctrl(input string label, input ctrl_t got, input ctrl_t exp);
        if (got !== exp) begin
            $display("** Error [%s] entry.ctrl: got 0x%h, expected 0x%h", label, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string label, input string sig, input logic got,
                             input logic exp);
        if (got !== exp) begin
            $display("** Error [%s] %s: got 0x%h, expected 0x%h", label, sig, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_idx(input string label, input string sig, input reg_idx_t got,
                             input reg_idx_t exp);
        if (got !== exp) begin
            $display("** Error [%s] %s: got 0x%h, expected 0x%h", label, sig, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d mismatches", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic apply_and_check(input string label, input rv_inst_u word, input fwd_t sel,
                                   input entry_t exp, input logic exp_map);
        wait_falls(1);
        inst = word;
        fwd  = sel;
        #SETTLE_NS;
        check_ctrl(label, entry.ctrl, exp.ctrl);
        check_entry(label, entry, exp);
        check_bit(label, "map_en", map_en, exp_map);
        check_idx(label, "rd", rd, exp.rd);
    endtask

    // Read through rs1 of an ADD to x0 so nothing gets mapped
    task automatic read_reg(input string label, input reg_idx_t r, input logic [31:0] vt,
                            input logic valid);
        apply_and_check(label, enc_r(7'h00, 5'd0, r, 3'b000, 5'd0, OP_REG), NO_FWD,
                        make_entry(32'h0, 1'b1, vt, valid, 5'd0, alu_ctrl(ALU_ADD)), 1'b0);
    endtask

    task automatic dispatch(input rv_inst_u word, input tag_t tag);
        wait_falls(1);
        inst        = word;
        alloc_tag   = tag;
        dispatch_en = 1'b1;
        wait_falls(1);
        dispatch_en = 1'b0;
    endtask

    task automatic writeback(input tag_t tag, input logic [31:0] data);
        wait_falls(1);
        wb = '{en: 1'b1, tag: 8'(tag), value: data};
        wait_falls(1);
        wb.en = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_read();
        apply_and_check("add", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OP_REG), NO_FWD,
                        make_entry(32'h0, 1'b1, 32'h0, 1'b1, 5'd3, alu_ctrl(ALU_ADD)), 1'b1);
        check_idx("add", "rs1", rs1, 5'd1);
        check_idx("add", "rs2", rs2, 5'd2);
        apply_and_check("sub", enc_r(7'h20, 5'd31, 5'd17, 3'b000, 5'd4, OP_REG), NO_FWD,
                        make_entry(32'h0, 1'b1, 32'h0, 1'b1, 5'd4, alu_ctrl(ALU_SUB)), 1'b1);
        check_idx("sub", "rs1", rs1, 5'd17);
        check_idx("sub", "rs2", rs2, 5'd31);
        finish_test("reset_read");
    endtask

    task automatic test_map();
        tag_t t;
        t = tag_t'($urandom());
        dispatch(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5, OP_REG), t);
        read_reg("x5_tagged", 5'd5, 32'(t), 1'b0);
        dispatch(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, OP_REG), ~t);
        read_reg("x0_zero", 5'd0, 32'h0, 1'b1);
        // map_en high but no dispatch strobe across this edge
        apply_and_check("add_x9", enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd9, OP_REG), NO_FWD,
                        make_entry(32'h0, 1'b1, 32'h0, 1'b1, 5'd9, alu_ctrl(ALU_ADD)), 1'b1);
        read_reg("x9_unmapped", 5'd9, 32'h0, 1'b1);
        finish_test("map");
    endtask

    task automatic test_writeback();
        tag_t        tag_a;
        tag_t        tag_b;
        logic [31:0] val;
        tag_a    = tag_t'($urandom());
        tag_b    = tag_t'($urandom());
        val      = $urandom();
        x7_tag   = tag_b ^ tag_t'(6'h2A);
        x6_value = val;
        dispatch(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd6, OP_REG), tag_a);
        writeback(tag_a ^ tag_t'(6'h01), $urandom());
        read_reg("x6_no_match", 5'd6, 32'(tag_a), 1'b0);
        writeback(tag_a, val);
        read_reg("x6_woken", 5'd6, val, 1'b1);
        dispatch(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd7, OP_REG), tag_b);

        // Remap x7 on the same edge as the writeback for its old tag
        wait_falls(1);
        inst        = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd7, OP_REG);
        alloc_tag   = x7_tag;
        dispatch_en = 1'b1;
        wb          = '{en: 1'b1, tag: 8'(tag_b), value: $urandom()};
        wait_falls(1);
        dispatch_en = 1'b0;
        wb.en       = 1'b0;
        read_reg("x7_map_wins", 5'd7, 32'(x7_tag), 1'b0);
        finish_test("writeback");
    endtask

    task automatic test_forwarding();
        logic [31:0] ex;
        logic [31:0] mem;
        rv_inst_u    add_w;
        ex    = $urandom();
        mem   = $urandom();
        add_w = enc_r(7'h00, 5'd6, 5'd7, 3'b000, 5'd8, OP_REG);
        wait_falls(1);
        ex_value  = ex;
        mem_value = mem;
        apply_and_check("fwd_ex_mem", add_w, fwd_t'{FWD_EX, FWD_MEM},
                        make_entry(mem, 1'b1, ex, 1'b1, 5'd8, alu_ctrl(ALU_ADD)), 1'b1);
        apply_and_check("fwd_mem_ex", add_w, fwd_t'{FWD_MEM, FWD_EX},
                        make_entry(ex, 1'b1, mem, 1'b1, 5'd8, alu_ctrl(ALU_ADD)), 1'b1);
        apply_and_check("fwd_code_11", add_w, fwd_t'{fwd_sel_e'(2'b11), FWD_STATUS},
                        make_entry(x6_value, 1'b1, 32'(x7_tag), 1'b0, 5'd8,
                                   alu_ctrl(ALU_ADD)), 1'b1);
        apply_and_check("fwd_imm", enc_i(12'h123, 5'd7, 3'b000, 5'd9, OP_IMM),
                        fwd_t'{FWD_EX, FWD_MEM},
                        make_entry(32'h123, 1'b1, ex, 1'b1, 5'd9, alu_ctrl(ALU_ADD)), 1'b1);
        finish_test("forwarding");
    endtask

    task automatic test_formats();
        wait_falls(1);
        pc = 32'h0000_1A40;
        apply_and_check("lui", enc_u(20'hABCDE, 5'd10, OP_LUI), NO_FWD,
                        make_entry(32'hABCD_E000, 1'b1, 32'h0, 1'b1, 5'd10,
                                   alu_ctrl(ALU_ADD)), 1'b1);
        apply_and_check("auipc", enc_u(20'h12345, 5'd11, OP_AUIPC), NO_FWD,
                        make_entry(32'h1234_5000, 1'b1, 32'h0000_1A40, 1'b1, 5'd11,
                                   alu_ctrl(ALU_ADD)), 1'b1);
        apply_and_check("xori", enc_i(12'hFFB, 5'd1, 3'b100, 5'd12, OP_IMM), NO_FWD,
                        make_entry(32'hFFFF_FFFB, 1'b1, 32'h0, 1'b1, 5'd12,
                                   alu_ctrl(ALU_XOR)), 1'b1);
        apply_and_check("srai", enc_i({7'h20, 5'd7}, 5'd1, 3'b101, 5'd13, OP_IMM), NO_FWD,
                        make_entry(32'h7, 1'b1, 32'h0, 1'b1, 5'd13, alu_ctrl(ALU_SRA)), 1'b1);
        apply_and_check("lw", enc_i(12'hFF0, 5'd2, 3'b010, 5'd14, OP_LOAD), NO_FWD,
                        make_entry(32'hFFFF_FFF0, 1'b1, 32'h0, 1'b1, 5'd14,
                                   make_ctrl(ALU_ADD, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, RS_LSU)),
                        1'b1);
        apply_and_check("sw", enc_s(12'h824, 5'd2, 5'd1, 3'b010, OP_STORE), NO_FWD,
                        make_entry(32'hFFFF_F824, 1'b1, 32'h0, 1'b1, 5'd4,
                                   make_ctrl(ALU_ADD, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, RS_LSU)),
                        1'b0);
        check_idx("sw", "rs1", rs1, 5'd1);
        check_idx("sw", "rs2", rs2, 5'd2);
        apply_and_check("bltu", enc_s(12'h010, 5'd2, 5'd1, 3'b110, OP_BRANCH), NO_FWD,
                        make_entry(32'h0, 1'b1, 32'h0, 1'b1, 5'd16,
                                   make_ctrl(ALU_SLTU, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
                                             RS_BRANCH)), 1'b0);
        wait_falls(1);
        inst = 32'hFFFF_FFFF;                  // Opcode 7'h7F is not supported
        #SETTLE_NS;
        check_ctrl("illegal", entry.ctrl, ctrl_t'('0));
        check_bit("illegal", "map_en", map_en, 1'b0);
        finish_test("formats");
    endtask

    initial begin
        void'($urandom(24478));
        reset        = 1'b1;
        inst         = '0;
        pc           = '0;
        dispatch_en  = 1'b0;
        alloc_tag    = '0;
        wb           = '0;
        ex_value     = '0;
        mem_value    = '0;
        fwd          = NO_FWD;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        wait_falls(10);
        reset = 1'b0;

        test_reset_read();
        test_map();
        test_writeback();
        test_forwarding();
        test_formats();

        $display("Summary: %0d tests passed, %0d failed, %0d mismatches",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
